// File: Makefile
# Verilator build for the IA tile loader
VERILATOR ?= verilator
TB_TOP    ?= tb_ia_loader
RTL_TOP   ?= ia_loader
FILELIST  ?= ia_loader.f
FLAGS     ?= --timing --assert -Wno-fatal
BUILD_DIR ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# exit status of the binary is the test verdict
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	./$(BUILD_DIR)/sim_$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: ia_loader.f
src/icb_pkg.sv
src/ia_pkg.sv
src/ia_cfg_regs.sv
src/ia_tile_walker.sv
src/ia_rsp_unpack.sv
src/ia_row_sender.sv
src/ia_loader.sv
verification/ia_mem_model.sv
verification/tb_ia_loader.sv

// File: src/ia_cfg_regs.sv
/*
 * configuration register block, latches cfg_in on an init_cfg pulse
 * while idle and derives the tile geometry with add-and-shift
 */
`timescale 1ns/1ps

module ia_cfg_regs #(
    parameter int SIZE = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               init_cfg,
    input  ia_pkg::ia_cfg_t    cfg_in,
    input  logic               busy,
    output ia_pkg::ia_cfg_t    cfg,
    output ia_pkg::tile_geom_t geom,
    output logic               start
);
    import ia_pkg::*;

    localparam int LOG = $clog2(SIZE);

    tile_geom_t geom_d;
    logic       accept;

    assign accept = init_cfg && !busy && !start;  // start pending counts as busy

    always_comb begin
        geom_d.row_tiles = (cfg_in.n + REG_W'(SIZE - 1)) >> LOG;
        geom_d.col_tiles = (cfg_in.k + REG_W'(SIZE - 1)) >> LOG;
        geom_d.loops     = (cfg_in.m + REG_W'(SIZE - 1)) >> LOG;
        // k mod SIZE or a full tile when zero
        geom_d.last_rows = (cfg_in.k[LOG-1:0] == '0) ? REG_W'(SIZE) : REG_W'(cfg_in.k[LOG-1:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            geom  <= '0;
            start <= 1'b0;
        end else begin
            start <= accept;        // walker kicks off next cycle
            if (accept) begin
                cfg  <= cfg_in;
                geom <= geom_d;
            end
        end
    end

    // no new configuration while a run is in flight
    a_cfg_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
        init_cfg |-> !busy);

endmodule

// File: src/ia_loader.sv
/*
 * IA tile loader top, reads input-activation tiles over the ICB read
 * bus and streams them row by row into the systolic array
 */
`timescale 1ns/1ps

module ia_loader #(
    parameter int SIZE = 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     init_cfg,
    input  ia_pkg::ia_cfg_t          cfg_in,
    input  logic                     cmd_ready,
    input  icb_pkg::icb_rsp_t        rd_rsp,
    input  logic                     send_ia_trigger,
    output icb_pkg::icb_cmd_t        rd_cmd,
    output logic                     rsp_ready,
    output ia_pkg::elem_t [SIZE-1:0] ia_out,
    output logic                     ia_row_valid,
    output logic                     ia_is_init_data,
    output logic                     ia_calc_done,
    output logic                     ia_sending_done,
    output logic                     ia_data_valid,
    output logic                     busy
);
    import ia_pkg::*;
    import icb_pkg::*;

    localparam int CW = $clog2(SIZE);

    ia_cfg_t                    cfg;
    tile_geom_t                 geom;
    logic                       start;
    logic [CW:0]                tile_rows;
    logic                       first_tile, last_tile;
    logic                       tile_loaded, rows_done;
    logic [BYTES_PER_BEAT-1:0]  wr_en;
    logic [CW-1:0]              wr_row, wr_col;
    elem_t [BYTES_PER_BEAT-1:0] wr_data;

    ia_cfg_regs #(.SIZE(SIZE)) u_cfg_regs (
        .clk, .rst_n, .init_cfg, .cfg_in, .busy,
        .cfg, .geom, .start
    );

    ia_tile_walker #(.SIZE(SIZE)) u_walker (
        .clk, .rst_n, .start, .cfg, .geom, .cmd_ready, .tile_loaded, .rows_done,
        .rd_cmd, .tile_rows, .first_tile, .last_tile, .busy
    );

    // responses only arrive while the walker has a run in flight
    ia_rsp_unpack #(.SIZE(SIZE)) u_unpack (
        .clk, .rst_n, .loading(busy), .cfg, .tile_rows, .rd_rsp,
        .rsp_ready, .wr_en, .wr_row, .wr_col, .wr_data, .tile_loaded
    );

    ia_row_sender #(.SIZE(SIZE)) u_sender (
        .clk, .rst_n, .wr_en, .wr_row, .wr_col, .wr_data, .tile_loaded,
        .tile_rows, .first_tile, .last_tile, .send_ia_trigger,
        .ia_out, .ia_row_valid, .ia_is_init_data, .ia_calc_done,
        .ia_data_valid, .ia_sending_done, .rows_done
    );

endmodule

// File: src/ia_pkg.sv
/*
 * element type, latched GEMM configuration and derived tile geometry
 * of the IA loader
 */
package ia_pkg;

    localparam int REG_W = 32;

    typedef logic signed [15:0] elem_t;   // s16 element fed to the array

    // ==================
    // configuration
    // ==================
    typedef struct packed {
        logic [REG_W-1:0]        k;          // IA rows
        logic [REG_W-1:0]        n;          // IA cols
        logic [REG_W-1:0]        m;          // OA cols setting the sweep count
        logic [REG_W-1:0]        base;       // byte address of IA[0][0]
        logic [REG_W-1:0]        stride;     // row pitch in bytes
        logic signed [REG_W-1:0] zp;         // added to every element
        logic                    use_16bits; // 1 s16, 0 s8
    } ia_cfg_t;

    // tile counts as ceil(x/SIZE)
    typedef struct packed {
        logic [REG_W-1:0] row_tiles;  // tiles per sweep from n
        logic [REG_W-1:0] col_tiles;  // tile rows from k
        logic [REG_W-1:0] loops;      // sweeps per tile row from m
        logic [REG_W-1:0] last_rows;  // valid rows in the last tile row
    } tile_geom_t;

endpackage

// File: src/ia_row_sender.sv
/*
 * SIZE x SIZE tile buffer, streams one row per cycle after a trigger
 * together with the first / last tile flags and the done pulses
 */
`timescale 1ns/1ps

module ia_row_sender #(
    parameter int SIZE = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [icb_pkg::BYTES_PER_BEAT-1:0] wr_en,
    input  logic [$clog2(SIZE)-1:0] wr_row,
    input  logic [$clog2(SIZE)-1:0] wr_col,
    input  ia_pkg::elem_t [icb_pkg::BYTES_PER_BEAT-1:0] wr_data,
    input  logic                  tile_loaded,
    input  logic [$clog2(SIZE):0] tile_rows,
    input  logic                  first_tile,
    input  logic                  last_tile,
    input  logic                  send_ia_trigger,
    output ia_pkg::elem_t [SIZE-1:0] ia_out,
    output logic                  ia_row_valid,
    output logic                  ia_is_init_data,
    output logic                  ia_calc_done,
    output logic                  ia_data_valid,
    output logic                  ia_sending_done,
    output logic                  rows_done
);
    import ia_pkg::*;
    import icb_pkg::*;

    localparam int CW = $clog2(SIZE);

    elem_t         tile_buf [SIZE][SIZE];
    logic [CW-1:0] row_idx;        // row on ia_out
    logic          sending;
    logic          data_valid_q;
    logic          last_row;

    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES_PER_BEAT; i++) begin
            if (wr_en[i])
                tile_buf[wr_row][wr_col + CW'(i)] <= wr_data[i];
        end
    end

    always_comb begin
        for (int c = 0; c < SIZE; c++)
            ia_out[c] = tile_buf[row_idx][c];
    end

    assign last_row        = {1'b0, row_idx} == tile_rows - 1'b1;
    assign ia_row_valid    = sending;
    assign ia_is_init_data = sending && first_tile;   // first tile of sweep
    assign ia_calc_done    = sending && last_tile;    // final partial sum
    assign ia_sending_done = sending && last_row;
    assign rows_done       = ia_sending_done;
    assign ia_data_valid   = data_valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_valid_q <= 1'b0;
            sending      <= 1'b0;
            row_idx      <= '0;
        end else if (tile_loaded) begin
            data_valid_q <= 1'b1;
        end else if (send_ia_trigger && data_valid_q) begin
            data_valid_q <= 1'b0;   // only a trigger on a full buffer starts rows
            sending      <= 1'b1;
            row_idx      <= '0;
        end else if (sending) begin
            if (last_row)
                sending <= 1'b0;
            else
                row_idx <= row_idx + 1'b1;
        end
    end

    // buffer is never refilled under an active stream
    a_no_send_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        (|wr_en || tile_loaded) |-> !ia_row_valid);

endmodule

// File: src/ia_rsp_unpack.sv
/*
 * read response unpacker, splits each beat into s8 or s16 lanes, adds
 * the zero point with s16 saturation and emits buffer writes
 */
`timescale 1ns/1ps

module ia_rsp_unpack #(
    parameter int SIZE = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  loading,
    input  ia_pkg::ia_cfg_t       cfg,
    input  logic [$clog2(SIZE):0] tile_rows,
    input  icb_pkg::icb_rsp_t     rd_rsp,
    output logic                  rsp_ready,
    output logic [icb_pkg::BYTES_PER_BEAT-1:0] wr_en,
    output logic [$clog2(SIZE)-1:0] wr_row,
    output logic [$clog2(SIZE)-1:0] wr_col,
    output ia_pkg::elem_t [icb_pkg::BYTES_PER_BEAT-1:0] wr_data,
    output logic                  tile_loaded
);
    import ia_pkg::*;
    import icb_pkg::*;

    localparam int CW    = $clog2(SIZE);
    localparam int LANES = BYTES_PER_BEAT;

    logic [CW-1:0] beat_cnt, row_cnt, beats_m1;
    logic          hs, last_beat, last_row;

    // sign-extended lane plus zp clamped to s16
    function automatic elem_t sat_add(input logic signed [15:0] v,
                                      input logic signed [REG_W-1:0] zp);
        logic signed [REG_W:0] s;
        s = v + zp;
        if (s > 32767)
            return 16'sh7fff;
        else if (s < -32768)
            return 16'sh8000;
        return s[15:0];
    endfunction

    assign rsp_ready   = loading;
    assign hs          = rd_rsp.valid && loading;
    assign beats_m1    = CW'(((SIZE << cfg.use_16bits) / LANES) - 1);
    assign last_beat   = beat_cnt == beats_m1;
    assign last_row    = {1'b0, row_cnt} == tile_rows - 1'b1;
    assign tile_loaded = hs && last_beat && last_row;
    assign wr_row      = row_cnt;
    assign wr_col      = cfg.use_16bits ? beat_cnt << ($clog2(LANES) - 1)
                                        : beat_cnt << $clog2(LANES);

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            logic signed [15:0] lane;
            if (cfg.use_16bits)
                lane = rd_rsp.rdata[16*(i % (LANES/2)) +: 16];   // upper lanes unused
            else
                lane = {{8{rd_rsp.rdata[8*i+7]}}, rd_rsp.rdata[8*i +: 8]};
            wr_data[i] = sat_add(lane, cfg.zp);
            wr_en[i]   = hs && (!cfg.use_16bits || i < LANES/2);
        end
    end

    // beat / row position within the tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (!loading) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (hs) begin
            if (last_beat) begin
                beat_cnt <= '0;
                row_cnt  <= last_row ? '0 : row_cnt + 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// File: src/ia_tile_walker.sv
/*
 * IDLE/LOAD/SEND control, walks tile column, sweep and tile row and
 * issues one read command per valid row of the current tile
 */
`timescale 1ns/1ps

module ia_tile_walker #(
    parameter int SIZE = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  ia_pkg::ia_cfg_t    cfg,
    input  ia_pkg::tile_geom_t geom,
    input  logic               cmd_ready,
    input  logic               tile_loaded,
    input  logic               rows_done,
    output icb_pkg::icb_cmd_t  rd_cmd,
    output logic [$clog2(SIZE):0] tile_rows,
    output logic               first_tile,
    output logic               last_tile,
    output logic               busy
);
    import ia_pkg::*;
    import icb_pkg::*;

    localparam int LOG = $clog2(SIZE);
    localparam int RW  = LOG + 1;

    typedef enum logic [1:0] {IDLE, LOAD, SEND} state_t;

    state_t           state;
    logic [REG_W-1:0] tc;           // tile column within sweep
    logic [REG_W-1:0] loop_cnt;     // sweep number
    logic [REG_W-1:0] tr;           // tile row
    logic [RW-1:0]    cmd_cnt;      // commands accepted this tile
    logic             cmd_valid;
    logic             kick;         // issue first row next cycle
    logic [ADDR_W-1:0] row_base;    // start of current tile row
    logic [ADDR_W-1:0] tile_addr;   // start of current tile
    logic [ADDR_W-1:0] cmd_addr;
    logic [ADDR_W-1:0] col_step;
    logic [ADDR_W-1:0] next_row_base;
    logic             last_col, last_loop, last_row, cmd_hs;

    assign last_col  = tc == geom.row_tiles - 1'b1;
    assign last_loop = loop_cnt == geom.loops - 1'b1;
    assign last_row  = tr == geom.col_tiles - 1'b1;
    assign cmd_hs    = cmd_valid && cmd_ready;

    assign tile_rows  = last_row ? geom.last_rows[RW-1:0] : RW'(SIZE);
    assign first_tile = tc == '0;
    assign last_tile  = last_col;
    assign busy       = state != IDLE;

    // SIZE elements of 1 or 2 bytes per tile
    assign col_step      = cfg.use_16bits ? ADDR_W'(2 * SIZE) : ADDR_W'(SIZE);
    assign next_row_base = row_base + (cfg.stride << LOG);  // SIZE rows down

    assign rd_cmd = '{
        valid: cmd_valid,
        addr:  cmd_addr,
        len:   8'(((SIZE << cfg.use_16bits) >> $clog2(BYTES_PER_BEAT)) - 1)
    };

    // ====================
    // state and tile indices
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            tc        <= '0;
            loop_cnt  <= '0;
            tr        <= '0;
            cmd_cnt   <= '0;
            cmd_valid <= 1'b0;
            kick      <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state     <= LOAD;
                    tc        <= '0;
                    loop_cnt  <= '0;
                    tr        <= '0;
                    cmd_cnt   <= '0;
                    cmd_valid <= 1'b1;   // first row straight away
                end
                LOAD: begin
                    kick <= 1'b0;
                    if (kick) begin
                        cmd_valid <= 1'b1;
                    end else if (cmd_hs) begin
                        cmd_cnt <= cmd_cnt + 1'b1;
                        if (cmd_cnt == tile_rows - 1'b1)
                            cmd_valid <= 1'b0;   // all rows requested
                    end
                    if (tile_loaded)
                        state <= SEND;
                end
                SEND: if (rows_done) begin
                    cmd_cnt <= '0;
                    if (last_row && last_loop && last_col) begin
                        state <= IDLE;           // whole matrix done
                    end else begin
                        state <= LOAD;
                        kick  <= 1'b1;
                        if (!last_col) begin
                            tc <= tc + 1'b1;
                        end else begin
                            tc <= '0;
                            if (last_loop) begin
                                loop_cnt <= '0;
                                tr       <= tr + 1'b1;
                            end else begin
                                loop_cnt <= loop_cnt + 1'b1;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ====================
    // address accumulation
    // ====================
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            row_base  <= cfg.base;
            tile_addr <= cfg.base;
            cmd_addr  <= cfg.base;
        end else if (state == LOAD && kick) begin
            cmd_addr <= tile_addr;
        end else if (cmd_hs) begin
            cmd_addr <= cmd_addr + cfg.stride;   // next row of tile
        end else if (state == SEND && rows_done) begin
            if (!last_col) begin
                tile_addr <= tile_addr + col_step;
            end else if (last_loop) begin
                row_base  <= next_row_base;
                tile_addr <= next_row_base;
            end else begin
                tile_addr <= row_base;           // rewind for next sweep
            end
        end
    end

    // payload held until accepted
    a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(rd_cmd));

endmodule

// File: src/icb_pkg.sv
/*
 * read-bus widths and the command / response payloads of the simplified
 * ICB read channel, shared by the loader and its memory model
 */
package icb_pkg;

    localparam int ADDR_W         = 32;
    localparam int BUS_W          = 32;
    localparam int BYTES_PER_BEAT = BUS_W / 8;

    // read command with len as beats minus one
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
    } icb_cmd_t;

    // read response beat with ready on its own wire back
    typedef struct packed {
        logic             valid;
        logic [BUS_W-1:0] rdata;
    } icb_rsp_t;

endpackage

// File: verification/ia_mem_model.sv
/*
 * byte-addressed read memory for the loader testbench, answers ICB read
 * commands in order with random idle beats and random cmd_ready stalls
 */
`timescale 1ns/1ps

module ia_mem_model #(
    parameter int MEM_BYTES = 2048
) (
    input  logic              clk,
    input  logic              rst_n,
    input  icb_pkg::icb_cmd_t rd_cmd,
    input  logic              rsp_ready,
    output logic              cmd_ready,
    output icb_pkg::icb_rsp_t rd_rsp
);
    import icb_pkg::*;

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0]        mem [MEM_BYTES];    // contents written by the testbench
    logic [ADDR_W-1:0] pend_addr [$];      // accepted bursts in arrival order
    logic [7:0]        pend_len [$];
    int                beat;               // beat within the oldest burst
    int                gap;                // idle cycles before next beat

    // little-endian beat starting at addr
    function automatic logic [BUS_W-1:0] read_beat(input logic [ADDR_W-1:0] addr);
        logic [BUS_W-1:0] d;
        for (int b = 0; b < BYTES_PER_BEAT; b++)
            d[8*b +: 8] = mem[AW'(addr + ADDR_W'(b))];
        return d;
    endfunction

    initial begin
        cmd_ready = 1'b0;
        rd_rsp    = '0;
        beat      = 0;
        gap       = 0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ready <= 1'b0;
            rd_rsp    <= '0;
            pend_addr.delete();
            pend_len.delete();
            beat = 0;
            gap  = 0;
        end else begin
            cmd_ready <= ($urandom % 4) != 0;   // stall about one cycle in four
            if (rd_cmd.valid && cmd_ready) begin
                pend_addr.push_back(rd_cmd.addr);
                pend_len.push_back(rd_cmd.len);
            end
            if (!rd_rsp.valid || rsp_ready) begin   // beat taken or none out
                if (gap > 0 || pend_addr.size() == 0) begin
                    rd_rsp.valid <= 1'b0;
                    if (gap > 0)
                        gap--;
                end else begin
                    rd_rsp.valid <= 1'b1;
                    rd_rsp.rdata <= read_beat(pend_addr[0] + ADDR_W'(BYTES_PER_BEAT * beat));
                    if (beat == int'(pend_len[0])) begin   // burst finished
                        void'(pend_addr.pop_front());
                        void'(pend_len.pop_front());
                        beat = 0;
                    end else begin
                        beat++;
                    end
                    gap = $urandom % 3;   // 0 to 2 idle cycles
                end
            end
        end
    end

endmodule

// File: verification/tb_ia_loader.sv
/*
 * directed testbench for the IA tile loader, random memory contents and
 * a reference model of tile layout, zero point and saturation
 */
`timescale 1ns/1ps

module tb_ia_loader;
    import ia_pkg::*;
    import icb_pkg::*;

    localparam int          SIZE      = 4;
    localparam int          MEM_BYTES = 2048;
    localparam int          TIMEOUT   = 400;   // cycles per wait
    localparam logic [31:0] SEED      = 32'h6d9a_b41e;
    localparam int          SEL_DATA  = 0;
    localparam int          SEL_ROW   = 1;
    localparam int          SEL_IDLE  = 2;

    logic             clk, rst_n, init_cfg, send_ia_trigger;
    ia_cfg_t          cfg_in;
    logic             cmd_ready, rsp_ready;
    icb_cmd_t         rd_cmd;
    icb_rsp_t         rd_rsp;
    elem_t [SIZE-1:0] ia_out;
    logic             ia_row_valid, ia_is_init_data, ia_calc_done;
    logic             ia_sending_done, ia_data_valid, busy;
    int               clamp_hi, clamp_lo;   // saturated elements seen by the model
    int               cmd_seen = 0;         // read commands accepted by memory
    int               cmd_expect;           // one per valid row of every tile so far

    ia_loader #(.SIZE(SIZE)) DUT (.*);

    ia_mem_model #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk, .rst_n, .rd_cmd, .rsp_ready, .cmd_ready, .rd_rsp
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // valid and ready are steady mid-cycle
    always @(negedge clk) begin
        if (rd_cmd.valid && cmd_ready)
            cmd_seen++;
    end

    // ====================
    // helpers
    // ====================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // sampled on the falling edge away from the driving edge
    task automatic wait_until(input int sel, input string what);
        int n;
        n = 0;
        forever begin
            @(negedge clk);
            if (sel == SEL_DATA && ia_data_valid)
                break;
            if (sel == SEL_ROW && ia_row_valid)
                break;
            if (sel == SEL_IDLE && !busy)
                break;
            n++;
            if (n > TIMEOUT)
                fail_run({"timeout while waiting for ", what});
        end
    endtask

    task automatic pulse_trigger();
        @(posedge clk);
        send_ia_trigger <= 1'b1;
        @(posedge clk);
        send_ia_trigger <= 1'b0;
    endtask

    // ====================
    // reference model
    // ====================
    function automatic elem_t expected_elem(input ia_cfg_t c, input int row, input int col);
        int addr, raw, v;
        addr = c.base + row * c.stride + col * (c.use_16bits ? 2 : 1);
        if (c.use_16bits)
            raw = $signed({u_mem.mem[addr + 1], u_mem.mem[addr]});   // little-endian
        else
            raw = $signed(u_mem.mem[addr]);
        v = raw + int'(c.zp);
        if (v > 32767) begin
            v = 32767;
            clamp_hi++;
        end else if (v < -32768) begin
            v = -32768;
            clamp_lo++;
        end
        return elem_t'(v);
    endfunction

    // trigger one tile and check every row with its flags
    task automatic send_tile(input ia_cfg_t c, input int tr, input int tc, input int rows,
                             input logic is_first, input logic is_last);
        elem_t exp;
        wait_until(SEL_DATA, "ia_data_valid");
        pulse_trigger();
        wait_until(SEL_ROW, "the first output row");
        for (int r = 0; r < rows; r++) begin
            check("ia_row_valid", ia_row_valid, 1);
            check("busy", busy, 1);
            check("ia_is_init_data", ia_is_init_data, is_first);
            check("ia_calc_done", ia_calc_done, is_last);
            check("ia_sending_done", ia_sending_done, r == rows - 1);
            for (int col = 0; col < SIZE; col++) begin
                exp = expected_elem(c, tr * SIZE + r, tc * SIZE + col);
                check($sformatf("ia_out[%0d]", col), ia_out[col], exp);
            end
            @(negedge clk);
        end
        check("ia_row_valid", ia_row_valid, 0);   // no extra rows
    endtask

    // configure and walk tile rows, sweeps and tile columns
    task automatic run_gemm(input int k, input int n, input int m, input int base,
                            input int stride, input int zp, input logic b16);
        ia_cfg_t c;
        int      row_tiles, col_tiles, loops, rows;
        c = '{k: k, n: n, m: m, base: base, stride: stride, zp: zp, use_16bits: b16};
        row_tiles = (n + SIZE - 1) / SIZE;
        col_tiles = (k + SIZE - 1) / SIZE;
        loops     = (m + SIZE - 1) / SIZE;
        @(posedge clk);
        cfg_in   <= c;
        init_cfg <= 1'b1;
        @(posedge clk);
        init_cfg <= 1'b0;
        for (int tr = 0; tr < col_tiles; tr++) begin
            rows = (tr == col_tiles - 1 && k % SIZE != 0) ? k % SIZE : SIZE;
            cmd_expect += rows * loops * row_tiles;   // rows past k never read
            for (int lp = 0; lp < loops; lp++)
                for (int tc = 0; tc < row_tiles; tc++)
                    send_tile(c, tr, tc, rows, tc == 0, tc == row_tiles - 1);
        end
        wait_until(SEL_IDLE, "busy to fall after the final tile");
        check("rd_cmd handshakes", cmd_seen, cmd_expect);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic s8_tile_order();
        run_gemm(8, 8, 4, 'h200, 8, 5, 1'b0);
    endtask

    task automatic s16_partial_tiles();
        run_gemm(6, 5, 8, 'h100, 32, -3, 1'b1);   // 2-row last tile and 2 sweeps
    endtask

    task automatic zero_point_saturation();
        clamp_hi = 0;
        clamp_lo = 0;
        run_gemm(4, 4, 4, 'h300, 8, 32700, 1'b1);
        run_gemm(4, 4, 4, 'h300, 8, -32700, 1'b1);
        if (clamp_hi == 0 || clamp_lo == 0)
            fail_run("zero point did not push any element into saturation");
    endtask

    task automatic tile_flags();
        run_gemm(4, 12, 4, 'h400, 12, 0, 1'b0);   // middle tile has neither flag
    endtask

    task automatic completion_idle();
        run_gemm(5, 4, 4, 'h500, 4, 1, 1'b0);
        check("ia_data_valid", ia_data_valid, 0);
        pulse_trigger();   // stray trigger must be ignored
        repeat (4) begin
            @(negedge clk);
            check("ia_row_valid", ia_row_valid, 0);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n           = 1'b0;
        init_cfg        = 1'b0;
        send_ia_trigger = 1'b0;
        cfg_in          = '0;
        clamp_hi        = 0;
        clamp_lo        = 0;
        cmd_expect      = 0;
        for (int a = 0; a < MEM_BYTES; a++)
            u_mem.mem[a] = 8'($urandom);
        @(negedge clk);
        check("rd_cmd.valid", rd_cmd.valid, 0);   // outputs quiet in reset
        check("rsp_ready", rsp_ready, 0);
        check("ia_row_valid", ia_row_valid, 0);
        check("ia_data_valid", ia_data_valid, 0);
        check("ia_sending_done", ia_sending_done, 0);
        check("busy", busy, 0);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        s8_tile_order();
        s16_partial_tiles();
        zero_point_saturation();
        tile_flags();
        completion_idle();
        $display("sim passed");
        $finish;
    end

endmodule
